// ==== verilog.f ====
+incdir+include
logic/sampling_pkg.sv
logic/sample_fifo.sv
logic/channel_unit.sv
logic/sample_collector.sv
logic/sampling_top.sv
tests/clock_gen.sv
tests/tb_sampling.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sampling testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tb_sampling -o tb_sampling
output=$(./obj_dir/tb_sampling)
echo "$output"
echo "$output" | grep -qx "NO ERRORS"

// ==== tests/tb_sampling.sv ====
// random-stimulus testbench for the sampling subsystem that checks FIFO output against a unit model
`default_nettype none
`include "sampling_defines.svh"

module tb_sampling import sampling_pkg::*; ();

  localparam int DEPTH  = `SMP_FIFO_DEPTH;
  localparam int NUNITS = `SMP_NUM_UNITS;
  // upper bounds per test in the order reset, sweep, filter, fifo reset, full reset and overflow
  localparam int RUN_CYCLES  = 5 + 150 + 100 + 110 + 260 + 250;
  localparam int CYCLE_LIMIT = RUN_CYCLES * 12 / 10; // 20 percent on top

  logic              clk;
  logic              rst;
  cmd_bus_t          cmd;
  logic [31:0]       current_time;
  logic [NUNITS-1:0] events;
  logic              sample_fifo_rd_en;
  fifo_entry_t       sample_data_out;
  fifo_status_t      fifo_status;
  logic              output_sample;
  logic [7:0]        channel_select;

  logic [31:0] rng_state = 32'h190f_64a0;
  int total [NUNITS];               // event pulses sent to each unit
  int tag_unit [$];                 // unit number held in each table slot in registration order
  int last_seen [`SMP_MAX_UNITS];   // last value the collector stored for each slot
  int errors;
  int checks;
  int tests;
  int errors_at_test_start;
  int cycles;

  clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  sampling_top u_sampling_top (
    .clk               (clk),
    .rst               (rst),
    .cmd               (cmd),
    .current_time      (current_time),
    .events            (events),
    .sample_fifo_rd_en (sample_fifo_rd_en),
    .sample_data_out   (sample_data_out),
    .fifo_status       (fifo_status),
    .output_sample     (output_sample),
    .channel_select    (channel_select)
  );

  // the time base runs freely and is nonzero soon after start so commands are accepted
  always @(posedge clk) begin
    #2;
    current_time = current_time + 32'd1;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13; // xorshift32 step
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
  endfunction

  // flags follow the occupancy and the threshold macros
  function automatic fifo_status_t expected_status(input int n);
    fifo_status_t s;
    s.empty        = (n == 0);
    s.almost_empty = (n <= `SMP_FIFO_AE);
    s.full         = (n == DEPTH);
    s.almost_full  = (n >= `SMP_FIFO_AF);
    s.data_count   = 16'(n);
    return s;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  task automatic compare_entry(input fifo_entry_t act, input fifo_entry_t exp);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("entry slot %0d value %0d, expected slot %0d value %0d",
                             act.tag, act.value, exp.tag, exp.value));
    end
  endtask

  task automatic compare_status(input fifo_status_t act, input fifo_status_t exp,
                                input string what);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("%s: count %0d flags %b, expected count %0d flags %b", what,
                             act.data_count, {act.empty, act.almost_empty, act.full,
                             act.almost_full}, exp.data_count, {exp.empty, exp.almost_empty,
                             exp.full, exp.almost_full}));
    end
  endtask

  task automatic compare_select(input logic [7:0] act, input logic [7:0] exp, input string what);
    checks++;
    if (act !== exp) report_error($sformatf("%s is %0d, expected %0d", what, act, exp));
  endtask

  task automatic compare_flag(input logic act, input logic exp, input string what);
    checks++;
    if (act !== exp) report_error($sformatf("%s is %b, expected %b", what, act, exp));
  endtask

  task automatic compare_count(input int act, input int exp, input string what);
    checks++;
    if (act != exp) report_error($sformatf("%s is %0d, expected %0d", what, act, exp));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2; // inputs change a little after the edge
    end
  endtask

  // one cycle with the given event pulses that the model counts as sent
  task automatic cycle_with(input logic [NUNITS-1:0] ev);
    int k;
    events = ev;
    for (k = 0; k < NUNITS; k++) begin
      if (ev[k]) total[k]++;
    end
    idle_cycles(1);
    events = '0;
  endtask

  task automatic random_events(input int n, input bit force_first);
    int i;
    for (i = 0; i < n; i++) begin
      if (i == 0 && force_first) cycle_with('1); // makes sure every unit moves
      else cycle_with(NUNITS'(next_rand()));
    end
  endtask

  task automatic write_reg(input logic [7:0] offset, input logic [31:0] data);
    cmd.addr = {`SMP_POSITION, offset};
    cmd.data = data;
    cmd.cs   = 1'b1;
    cmd.wr   = 1'b1;
    idle_cycles(1);
    cmd = '0;
  endtask

  task automatic send_command(input logic [31:0] code);
    write_reg(`SMP_ADDR_LOCAL_COMMAND, code);
  endtask

  task automatic register_unit(input int k);
    write_reg(`SMP_ADDR_NEW_UNIT, 32'(`SMP_UNIT_BASE + k));
    idle_cycles(4); // the count moves two cycles after the strobe falls
    tag_unit.push_back(k);
  endtask

  // shuffle the units and register a random number of them from the front
  task automatic register_random_subset();
    int order [NUNITS];
    int i;
    int j;
    int tmp;
    int n;
    for (i = 0; i < NUNITS; i++) order[i] = i;
    for (i = NUNITS - 1; i > 0; i--) begin
      j        = rand_below(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    n = 1 + rand_below(NUNITS);
    for (i = 0; i < n; i++) register_unit(order[i]);
  endtask

  task automatic forget_units();
    int t;
    tag_unit.delete();
    for (t = 0; t < `SMP_MAX_UNITS; t++) last_seen[t] = 0; // RESET zeroes the stored values
  endtask

  function automatic int count_changed();
    int t;
    int n;
    n = 0;
    for (t = 0; t < tag_unit.size(); t++) begin
      if (total[tag_unit[t]] != last_seen[t]) n++;
    end
    return n;
  endfunction

  task automatic mark_stored();
    int t;
    for (t = 0; t < tag_unit.size(); t++) last_seen[t] = total[tag_unit[t]];
  endtask

  // output_sample low for longer than one visit means the FSM sits in idle
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 6) begin
      quiet = output_sample ? 0 : quiet + 1;
      idle_cycles(1);
    end
  endtask

  task automatic pop_entry();
    sample_fifo_rd_en = 1'b1;
    idle_cycles(1);
    sample_fifo_rd_en = 1'b0;
  endtask

  // entries from a live sweep must rise per slot and stay within the unit's total
  task automatic check_sweep_entry(input fifo_entry_t e);
    int t;
    int limit;
    t = int'(e.tag);
    checks++;
    if (t >= tag_unit.size()) begin
      report_error($sformatf("entry tag %0d is not a registered slot", t));
    end else begin
      limit = total[tag_unit[t]] % 4096; // the entry keeps only 12 bits
      if (int'(e.value) <= last_seen[t]) begin
        report_error($sformatf("slot %0d value %0d does not rise above %0d", t, e.value,
                               last_seen[t]));
      end else if (int'(e.value) > limit) begin
        report_error($sformatf("slot %0d value %0d exceeds event total %0d", t, e.value, limit));
      end
      last_seen[t] = int'(e.value);
    end
  endtask

  task automatic drain_sweep(output int n);
    n = 0;
    while (!fifo_status.empty) begin
      check_sweep_entry(sample_data_out);
      pop_entry();
      n++;
    end
  endtask

  // with quiet events each changed slot gives exactly one entry equal to its total
  task automatic drain_exact();
    bit          pending [`SMP_MAX_UNITS];
    fifo_entry_t exp_e;
    int          t;
    for (t = 0; t < `SMP_MAX_UNITS; t++) begin
      pending[t] = (t < tag_unit.size()) && (total[tag_unit[t]] != last_seen[t]);
    end
    while (!fifo_status.empty) begin
      t = int'(sample_data_out.tag);
      if (t < tag_unit.size() && pending[t]) begin
        exp_e.tag   = 4'(t);
        exp_e.value = 12'(total[tag_unit[t]]);
        compare_entry(sample_data_out, exp_e);
        pending[t]   = 1'b0;
        last_seen[t] = total[tag_unit[t]];
      end else begin
        report_error($sformatf("unexpected entry for slot %0d", t));
      end
      pop_entry();
    end
    for (t = 0; t < `SMP_MAX_UNITS; t++) begin
      if (pending[t]) report_error($sformatf("no entry came out for changed slot %0d", t));
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_test_start) $display("test %0s: pass", name);
    else $display("test %0s: fail with %0d errors", name, errors - errors_at_test_start);
    errors_at_test_start = errors;
  endtask

  initial begin
    int n;
    cmd               = '0;
    current_time      = '0;
    events            = '0;
    sample_fifo_rd_en = 1'b0;
    @(posedge clk);
    while (rst) @(posedge clk);
    #2;

    compare_flag(output_sample, 1'b0, "output_sample after reset");
    compare_select(channel_select, `SMP_NO_CHANNEL, "channel_select after reset");
    compare_status(fifo_status, expected_status(0), "after reset");
    end_test("reset_state");

    register_random_subset();
    random_events(20, 1'b1);
    send_command(`SMP_CMD_START);
    random_events(60, 1'b0);      // events keep arriving while the units are polled
    send_command(`SMP_CMD_STOP);
    wait_idle();
    drain_sweep(n);
    if (n == 0) report_error("the sweep produced no entries");
    end_test("register_sweep");

    send_command(`SMP_CMD_START);
    idle_cycles(64);              // several full sweeps with the units quiet
    send_command(`SMP_CMD_STOP);
    wait_idle();
    drain_exact();
    end_test("duplicate_filter");

    random_events(20, 1'b1);
    send_command(`SMP_CMD_START);
    idle_cycles(64);
    send_command(`SMP_CMD_STOP);
    wait_idle();
    compare_status(fifo_status, expected_status(count_changed()), "before fifo reset");
    mark_stored();                // the collector has already recorded these values
    send_command(`SMP_CMD_RES_FIFO);
    idle_cycles(2);               // one cycle to load the command and one for idle to act
    compare_status(fifo_status, expected_status(0), "after fifo reset");
    end_test("fifo_reset");

    send_command(`SMP_CMD_RESET);
    idle_cycles(2);
    forget_units();
    compare_select(channel_select, `SMP_NO_CHANNEL, "channel_select after full reset");
    compare_status(fifo_status, expected_status(0), "after full reset");
    send_command(`SMP_CMD_START);
    idle_cycles(32);
    compare_status(fifo_status, expected_status(0), "sampling an empty table");
    send_command(`SMP_CMD_STOP);
    wait_idle();
    register_random_subset();
    random_events(20, 1'b1);
    send_command(`SMP_CMD_START);
    idle_cycles(128);             // the index may first run through the empty slots
    send_command(`SMP_CMD_STOP);
    wait_idle();
    drain_exact();
    end_test("full_reset");

    send_command(`SMP_CMD_START);
    while (!fifo_status.full) cycle_with('1);
    repeat (20) begin
      cycle_with('1);
      compare_status(fifo_status, expected_status(DEPTH), "while full");
    end
    send_command(`SMP_CMD_STOP);
    wait_idle();
    drain_sweep(n);
    compare_count(n, DEPTH, "entries drained after overflow");
    end_test("overflow");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
// clock and reset source for the sampling testbench, instantiated once at the testbench top
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 10; // gives a period of 20 time units

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset covers the first two rising edges and drops just after the second
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/sampling_top.sv ====
// top level of the sampling subsystem, chains the channel units into the collector
`default_nettype none
`include "sampling_defines.svh"

module sampling_top import sampling_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  cmd_bus_t                  cmd,
  input  logic [31:0]               current_time,
  input  logic [`SMP_NUM_UNITS-1:0] events,
  input  logic                      sample_fifo_rd_en,
  output fifo_entry_t               sample_data_out,
  output fifo_status_t              fifo_status,
  output logic                      output_sample,
  output logic [7:0]                channel_select
);

  // chain[k] feeds unit k and chain[SMP_NUM_UNITS] is what the collector samples
  sample_t chain [`SMP_NUM_UNITS + 1];

  assign chain[0] = '0; // nothing sits upstream of unit 0

  for (genvar k = 0; k < `SMP_NUM_UNITS; k++) begin : g_unit
    channel_unit #(
      .UNIT_POSITION (`SMP_UNIT_BASE + k)
    ) u_channel_unit (
      .clk            (clk),
      .rst            (rst),
      .event_pulse    (events[k]),
      .output_sample  (output_sample),
      .channel_select (channel_select),
      .chain_in       (chain[k]),
      .chain_out      (chain[k+1])
    );
  end

  sample_collector u_sample_collector (
    .clk               (clk),
    .rst               (rst),
    .cmd               (cmd),
    .current_time      (current_time),
    .sample_data       (chain[`SMP_NUM_UNITS]),
    .output_sample     (output_sample),
    .channel_select    (channel_select),
    .sample_fifo_rd_en (sample_fifo_rd_en),
    .sample_data_out   (sample_data_out),
    .fifo_status       (fifo_status)
  );

endmodule

`default_nettype wire

// ==== logic/sample_collector.sv ====
// command decoder and polling FSM that gathers changed unit samples into the sample FIFO
`default_nettype none
`include "sampling_defines.svh"

module sample_collector import sampling_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  cmd_bus_t     cmd,
  input  logic [31:0]  current_time,
  input  sample_t      sample_data,
  output logic         output_sample,
  output logic [7:0]   channel_select,
  input  logic         sample_fifo_rd_en,
  output fifo_entry_t  sample_data_out,
  output fifo_status_t fifo_status
);

  localparam int NW = $clog2(`SMP_MAX_UNITS + 1); // unit count must reach the table size
  localparam int IW = $clog2(`SMP_MAX_UNITS);     // table index width, matches the entry tag

  typedef enum logic [2:0] {
    s_idle,
    s_fetch,
    s_fetch_wait,
    s_store,
    s_increment
  } state_t;

  state_t        state;
  state_t        next_state;
  logic [31:0]   command;                        // last command written by the host
  logic [7:0]    unit_table [`SMP_MAX_UNITS];    // positions of registered units
  sample_t       last_value [`SMP_MAX_UNITS];    // last value stored per table slot
  logic [NW-1:0] num_units;
  logic [IW-1:0] cur_idx;                        // slot being visited

  logic        ctrl_wr;       // qualified write to this block
  logic        new_unit_wr;
  logic        cmd_wr;
  logic        new_unit_d;    // two-stage delay of the registration write
  logic        new_unit_dd;
  logic        new_unit_done; // falling edge of a registration burst
  logic        clr_cmd;
  logic        res_sampling;
  logic        res_fifo;
  logic        inc_idx;
  logic        fifo_wr;
  logic        fifo_rst;
  fifo_entry_t fifo_din;

  assign ctrl_wr     = cmd.cs && cmd.wr && (cmd.addr[15:8] == `SMP_POSITION);
  assign new_unit_wr = ctrl_wr && (cmd.addr[7:0] == `SMP_ADDR_NEW_UNIT);
  assign cmd_wr      = ctrl_wr && (cmd.addr[7:0] == `SMP_ADDR_LOCAL_COMMAND);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state    = state;
    output_sample = 1'b0;
    clr_cmd       = 1'b0;
    res_sampling  = 1'b0;
    res_fifo      = 1'b0;
    inc_idx       = 1'b0;
    fifo_wr       = 1'b0;
    case (state)
      s_idle: begin
        // commands are held off until the time base is running
        if (current_time != 32'd0) begin
          if (command == `SMP_CMD_START) begin
            clr_cmd    = 1'b1;
            next_state = s_fetch;
          end else if (command == `SMP_CMD_RESET) begin
            res_sampling = 1'b1;
          end else if (command == `SMP_CMD_RES_FIFO) begin
            res_fifo = 1'b1;
            clr_cmd  = 1'b1;
          end
        end
      end
      s_fetch: begin
        output_sample = 1'b1; // the addressed unit latches its count this cycle
        next_state    = s_fetch_wait;
      end
      s_fetch_wait: begin
        output_sample = 1'b1; // gives the value time to ripple down the chain
        next_state    = s_store;
      end
      s_store: begin
        // only a changed value makes an entry
        fifo_wr    = (last_value[cur_idx] != sample_data);
        next_state = s_increment;
      end
      s_increment: begin
        inc_idx    = 1'b1;
        next_state = s_fetch;
        if (command == `SMP_CMD_RESET) begin
          res_sampling = 1'b1;
          next_state   = s_idle;
        end else if (command == `SMP_CMD_STOP) begin
          clr_cmd    = 1'b1;
          next_state = s_idle;
        end
      end
      default: begin
        next_state = s_idle;
      end
    endcase
  end

  // a registration burst is finished once the delayed strobe has fallen
  always_ff @(posedge clk) begin
    if (rst) begin
      new_unit_d  <= 1'b0;
      new_unit_dd <= 1'b0;
    end else begin
      new_unit_d  <= new_unit_wr;
      new_unit_dd <= new_unit_d;
    end
  end

  assign new_unit_done = new_unit_dd && !new_unit_d;

  always_ff @(posedge clk) begin
    if (rst || res_sampling) begin
      for (int i = 0; i < `SMP_MAX_UNITS; i++) begin
        unit_table[i] <= `SMP_NO_CHANNEL; // every slot starts out empty
        last_value[i] <= '0;
      end
      num_units <= '0;
      cur_idx   <= '0;
    end else begin
      // the slot is chosen by the current count and writes past the table are ignored
      if (new_unit_wr && (num_units < NW'(`SMP_MAX_UNITS))) begin
        unit_table[num_units[IW-1:0]] <= cmd.data[7:0];
      end
      if (new_unit_done && (num_units < NW'(`SMP_MAX_UNITS))) begin
        num_units <= num_units + 1'b1;
      end
      if (fifo_wr) begin
        last_value[cur_idx] <= sample_data;
      end
      if (inc_idx) begin
        // wrap back to slot 0 after the last registered unit
        if ({1'b0, cur_idx} == num_units - 1'b1) begin
          cur_idx <= '0;
        end else begin
          cur_idx <= cur_idx + 1'b1;
        end
      end
    end
  end

  // a host write in the same cycle as a clear wins over the clear
  always_ff @(posedge clk) begin
    if (rst) begin
      command <= '0;
    end else begin
      if (clr_cmd || res_sampling) begin
        command <= '0;
      end
      if (cmd_wr) begin
        command <= cmd.data;
      end
    end
  end

  assign channel_select = unit_table[cur_idx];

  assign fifo_din.tag   = cur_idx;
  assign fifo_din.value = sample_data[11:0];
  assign fifo_rst       = rst || res_fifo || res_sampling;

  sample_fifo #(
    .payload_t (fifo_entry_t),
    .DEPTH     (`SMP_FIFO_DEPTH)
  ) u_sample_fifo (
    .clk    (clk),
    .rst    (fifo_rst),
    .din    (fifo_din),
    .wr_en  (fifo_wr),
    .rd_en  (sample_fifo_rd_en),
    .dout   (sample_data_out),
    .status (fifo_status)
  );

endmodule

`default_nettype wire

// ==== logic/channel_unit.sv ====
// pulse-counting measurement unit that forms one link of the sample chain the collector polls
`default_nettype none

module channel_unit import sampling_pkg::*; #(
  parameter int UNIT_POSITION = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       event_pulse,
  input  logic       output_sample,
  input  logic [7:0] channel_select,
  input  sample_t    chain_in,
  output sample_t    chain_out
);

  localparam logic [7:0] MY_POSITION = 8'(UNIT_POSITION);

  logic [31:0] event_count; // running total of event pulses
  sample_t     hold;        // value offered to the collector
  logic        holding;     // set while this unit owns the chain
  logic        selected;

  // the collector names one unit at a time so only one link can be selected
  assign selected = output_sample && (channel_select == MY_POSITION);

  always_ff @(posedge clk) begin
    if (rst) begin
      event_count <= '0;
    end else if (event_pulse) begin
      event_count <= event_count + 32'd1; // events arrive as single-cycle pulses
    end
  end

  // the count is copied for the collector while this unit is selected
  always_ff @(posedge clk) begin
    if (selected) begin
      hold <= event_count; // refreshed on every selected cycle of the fetch window
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      holding <= 1'b0;
    end else if (selected) begin
      holding <= 1'b1;
    end else if (!output_sample) begin
      // the flag stays up through the store cycle and drops at its end
      holding <= 1'b0;
    end
  end

  // drive the latched count while holding and pass the upstream value otherwise
  assign chain_out = holding ? hold : chain_in;

endmodule

`default_nettype wire

// ==== logic/sample_fifo.sv ====
// synchronous FIFO with a type parameter payload that the collector uses to buffer samples
`default_nettype none
`include "sampling_defines.svh"

module sample_fifo import sampling_pkg::*; #(
  parameter type payload_t = fifo_entry_t,
  parameter int  DEPTH     = `SMP_FIFO_DEPTH
) (
  input  logic         clk,
  input  logic         rst,
  input  payload_t     din,
  input  logic         wr_en,
  input  logic         rd_en,
  output payload_t     dout,
  output fifo_status_t status
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // pointer width
  localparam int CW = $clog2(DEPTH + 1);               // count has to reach DEPTH itself

  payload_t        mem [DEPTH]; // entries between the read and write pointers are valid
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_wr;
  logic            do_rd;

  // a full FIFO drops the write and an empty one ignores the read
  assign do_wr = wr_en && (count != CW'(DEPTH));
  assign do_rd = rd_en && (count != '0);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap at the last slot
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // a read and a write in the same cycle leave the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  assign dout = mem[rd_ptr]; // head entry is visible before the read strobe

  assign status.empty        = (count == '0);
  assign status.almost_empty = (count <= CW'(`SMP_FIFO_AE));
  assign status.full         = (count == CW'(DEPTH));
  assign status.almost_full  = (count >= CW'(`SMP_FIFO_AF));
  assign status.data_count   = 16'(count);

endmodule

`default_nettype wire

// ==== logic/sampling_pkg.sv ====
// types shared by the sampling RTL and its testbench, imported with a wildcard where used
`default_nettype none

package sampling_pkg;

  // value a unit places on the sample chain
  typedef logic [31:0] sample_t;

  // one host write on the command bus
  // a write counts only when cs and wr are both high in the same cycle
  typedef struct packed {
    logic [15:0] addr; // upper byte selects the block and lower byte the register
    logic [31:0] data; // register payload
    logic        cs;   // chip select
    logic        wr;   // write strobe
  } cmd_bus_t;

  // one FIFO entry as the host sees it
  typedef struct packed {
    logic [3:0]  tag;   // table index of the unit that produced the value
    logic [11:0] value; // low bits of the sampled count
  } fifo_entry_t;

  // FIFO level flags and occupancy
  typedef struct packed {
    logic        empty;        // no entry to read
    logic        almost_empty; // count at or below the almost-empty threshold
    logic        full;         // writes are being dropped
    logic        almost_full;  // count at or above the almost-full threshold
    logic [15:0] data_count;   // entries currently stored
  } fifo_status_t;

endpackage

`default_nettype wire

// ==== include/sampling_defines.svh ====
// sampling subsystem constants that the RTL and testbench pull in with `include
`ifndef SAMPLING_DEFINES_SVH
`define SAMPLING_DEFINES_SVH

// block address of the collector on the command bus as matched against addr[15:8]
`define SMP_POSITION 8'd242

// register offsets inside the collector block as matched against addr[7:0]
`define SMP_ADDR_NEW_UNIT      8'd4 // data[7:0] names a unit to add to the table
`define SMP_ADDR_LOCAL_COMMAND 8'd5 // data is loaded into the command register

// command codes written to the command register
`define SMP_CMD_START    32'd1 // leave idle and begin polling
`define SMP_CMD_STOP     32'd2 // return to idle after the current visit
`define SMP_CMD_RES_FIFO 32'd3 // empty the sample FIFO while idle
`define SMP_CMD_RESET    32'd5 // clear table, last values, count, index and FIFO

// marks a table slot that holds no unit
`define SMP_NO_CHANNEL 8'd255

// number of channel units built into the top level
`define SMP_NUM_UNITS 4

// capacity of the collector's unit table
`define SMP_MAX_UNITS 16

// sample FIFO geometry and level thresholds
`define SMP_FIFO_DEPTH 32
`define SMP_FIFO_AF    28 // almost full at this data count or above
`define SMP_FIFO_AE    2  // almost empty at this data count or below

// unit k answers to channel_select equal to SMP_UNIT_BASE plus k
`define SMP_UNIT_BASE 16

`endif
